//--- fu_config.svh
`ifndef FU_CONFIG_SVH
`define FU_CONFIG_SVH

// one machine word
`define XLEN 32

// shift amount field of operand b
`define SHAMT_BITS 5

// edges from slot fill to result valid, sized to cover the multiplier
`define ALU_LATENCY 3

// driven out for a function code outside the defined set
`define ALU_BAD_RESULT 32'hfacebeec

`endif

//--- fu_pkg.sv
`include "fu_config.svh"

package fu_pkg;

	typedef enum logic [3:0] {
		ALU_ADD    = 4'h0,
		ALU_SUB    = 4'h1,
		ALU_AND    = 4'h2,
		ALU_OR     = 4'h3,
		ALU_XOR    = 4'h4,
		ALU_SLT    = 4'h5,
		ALU_SLTU   = 4'h6,
		ALU_SLL    = 4'h7,
		ALU_SRL    = 4'h8,
		ALU_SRA    = 4'h9,
		ALU_MUL    = 4'ha,
		ALU_MULH   = 4'hb,
		ALU_MULHSU = 4'hc,
		ALU_MULHU  = 4'hd // 4'he and 4'hf are undefined
	} alu_func_e;

	typedef enum logic [1:0] {
		OPA_IS_RS1  = 2'h0,
		OPA_IS_NPC  = 2'h1,
		OPA_IS_PC   = 2'h2,
		OPA_IS_ZERO = 2'h3
	} opa_sel_e;

	typedef enum logic [2:0] {
		OPB_IS_RS2   = 3'h0,
		OPB_IS_I_IMM = 3'h1,
		OPB_IS_S_IMM = 3'h2,
		OPB_IS_B_IMM = 3'h3,
		OPB_IS_U_IMM = 3'h4,
		OPB_IS_J_IMM = 3'h5
	} opb_sel_e;

	// rv32 base formats, msb first
	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_type_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_type_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		logic [6:0] opcode;
	} s_type_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3; // branch condition
		logic [3:0] imm_4_1;
		logic       imm_11;
		logic [6:0] opcode;
	} b_type_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_type_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_type_t;

	typedef union packed {
		r_type_t r;
		i_type_t i;
		s_type_t s;
		b_type_t b;
		u_type_t u;
		j_type_t j;
	} inst_u;

	typedef struct packed {
		logic              valid;
		logic [`XLEN-1:0]  pc;
		logic [`XLEN-1:0]  npc;
		inst_u             inst;
		opa_sel_e          opa_select;
		opb_sel_e          opb_select;
		alu_func_e         alu_func;
		logic              cond_branch;
		logic              uncond_branch;
		logic [4:0]        dest_reg;
	} dispatch_packet_t;

	typedef struct packed {
		logic             valid;
		logic [`XLEN-1:0] rs1_value;
		logic [`XLEN-1:0] rs2_value;
	} operand_packet_t;

	typedef struct packed {
		logic [`XLEN-1:0] npc;
		logic [`XLEN-1:0] alu_result;
		logic             take_branch;
		logic [4:0]       dest_reg;
		logic [`XLEN-1:0] rs2_value; // store data for the memory stage
	} fu_result_t;

endpackage

//--- fu_slot.sv
`timescale 1ns/100ps

`include "fu_config.svh"

module fu_slot (
	input  logic                      clock,
	input  logic                      reset,
	input  fu_pkg::dispatch_packet_t  dispatch,
	input  fu_pkg::operand_packet_t   operands,
	input  logic                      select,
	input  logic                      squash,
	output fu_pkg::dispatch_packet_t  held_dispatch,
	output fu_pkg::operand_packet_t   held_operands,
	output logic                      restart,
	output logic                      slot_busy
);

	logic dispatch_free; // instruction register empty or emptying
	logic operands_free;
	logic have_dispatch; // an instruction is held after this edge
	logic take_dispatch;
	logic take_operands;

	// select frees both halves on the same edge it refills them
	always_comb begin
		dispatch_free = ~held_dispatch.valid | select;
		operands_free = ~held_operands.valid | select;
		take_dispatch = dispatch.valid & dispatch_free;
		have_dispatch = take_dispatch | (held_dispatch.valid & ~select);
		// operands never arrive ahead of their instruction
		take_operands = operands.valid & operands_free & have_dispatch;
	end

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			held_dispatch <= '0;
		end else if (take_dispatch) begin
			held_dispatch <= dispatch;
		end else if (select) begin
			held_dispatch <= '0; // released, nothing waiting
		end
	end

	always_ff @(posedge clock) begin
		if (reset || squash) begin
			held_operands <= '0;
		end else if (take_operands) begin
			held_operands <= operands;
		end else if (select) begin
			held_operands <= '0;
		end
	end

	// contents changed on the previous edge, tell the alu to count again
	always_ff @(posedge clock) begin
		if (reset) begin
			restart <= 1'b0;
		end else begin
			restart <= select | squash;
		end
	end

	assign slot_busy = held_dispatch.valid;

endmodule

//--- fu_operand_mux.sv
`timescale 1ns/100ps

`include "fu_config.svh"

module fu_operand_mux (
	input  fu_pkg::dispatch_packet_t  held_dispatch,
	input  fu_pkg::operand_packet_t   held_operands,
	output logic [`XLEN-1:0]          opa,
	output logic [`XLEN-1:0]          opb
);

	fu_pkg::inst_u    inst;
	logic [`XLEN-1:0] i_imm;
	logic [`XLEN-1:0] s_imm;
	logic [`XLEN-1:0] b_imm;
	logic [`XLEN-1:0] u_imm;
	logic [`XLEN-1:0] j_imm;

	assign inst = held_dispatch.inst;

	// sign extended immediates, one per format
	assign i_imm = {{(`XLEN-12){inst.i.imm[11]}}, inst.i.imm};
	assign s_imm = {{(`XLEN-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
	assign b_imm = {{(`XLEN-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
		inst.b.imm_10_5, inst.b.imm_4_1, 1'b0}; // halfword aligned
	assign u_imm = {inst.u.imm_31_12, 12'b0};
	assign j_imm = {{(`XLEN-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
		inst.j.imm_11, inst.j.imm_10_1, 1'b0};

	always_comb begin
		case (held_dispatch.opa_select)
			fu_pkg::OPA_IS_RS1:  opa = held_operands.rs1_value;
			fu_pkg::OPA_IS_NPC:  opa = held_dispatch.npc;
			fu_pkg::OPA_IS_PC:   opa = held_dispatch.pc;
			fu_pkg::OPA_IS_ZERO: opa = '0;
			default:             opa = '0;
		endcase
	end

	always_comb begin
		case (held_dispatch.opb_select)
			fu_pkg::OPB_IS_RS2:   opb = held_operands.rs2_value;
			fu_pkg::OPB_IS_I_IMM: opb = i_imm;
			fu_pkg::OPB_IS_S_IMM: opb = s_imm;
			fu_pkg::OPB_IS_B_IMM: opb = b_imm;
			fu_pkg::OPB_IS_U_IMM: opb = u_imm;
			fu_pkg::OPB_IS_J_IMM: opb = j_imm;
			default:              opb = '0; // two unused codes
		endcase
	end

endmodule

//--- alu_core.sv
`timescale 1ns/100ps

`include "fu_config.svh"

module alu_core (
	input  logic               clock,
	input  logic               reset,
	input  logic               restart,
	input  logic               operands_valid,
	input  logic [`XLEN-1:0]   opa,
	input  logic [`XLEN-1:0]   opb,
	input  logic [`XLEN-1:0]   rs1_value,
	input  logic [`XLEN-1:0]   rs2_value,
	input  fu_pkg::alu_func_e  func,
	input  logic [2:0]         br_funct3,
	output logic               valid,
	output logic [`XLEN-1:0]   alu_result,
	output logic               cond
);

	logic signed [`XLEN-1:0]     signed_opa;
	logic signed [`XLEN-1:0]     signed_opb;
	logic signed [`XLEN:0]       opa_sext; // one extra bit for the mixed product
	logic signed [`XLEN:0]       opb_zext;
	logic signed [2*`XLEN-1:0]   signed_product;
	logic signed [2*`XLEN+1:0]   mixed_product;
	logic        [2*`XLEN-1:0]   unsigned_product;
	logic        [`SHAMT_BITS-1:0] shamt;
	logic        [`XLEN-1:0]     next_result;
	logic                        next_cond;
	logic        [`ALU_LATENCY-1:0] count; // one-hot, saturates in the top bit
	logic                        valid_q;

	assign signed_opa = opa;
	assign signed_opb = opb;
	assign opa_sext   = {opa[`XLEN-1], opa};
	assign opb_zext   = {1'b0, opb};
	assign shamt      = opb[`SHAMT_BITS-1:0];

	assign signed_product   = signed_opa * signed_opb;
	assign mixed_product    = opa_sext * opb_zext; // rs1 signed times rs2 unsigned
	assign unsigned_product = opa * opb;

	always_comb begin
		case (func)
			fu_pkg::ALU_ADD:    next_result = opa + opb;
			fu_pkg::ALU_SUB:    next_result = opa - opb;
			fu_pkg::ALU_AND:    next_result = opa & opb;
			fu_pkg::ALU_OR:     next_result = opa | opb;
			fu_pkg::ALU_XOR:    next_result = opa ^ opb;
			fu_pkg::ALU_SLT:    next_result = `XLEN'(signed_opa < signed_opb);
			fu_pkg::ALU_SLTU:   next_result = `XLEN'(opa < opb);
			fu_pkg::ALU_SLL:    next_result = opa << shamt;
			fu_pkg::ALU_SRL:    next_result = opa >> shamt;
			fu_pkg::ALU_SRA:    next_result = signed_opa >>> shamt;
			fu_pkg::ALU_MUL:    next_result = signed_product[`XLEN-1:0];
			fu_pkg::ALU_MULH:   next_result = signed_product[2*`XLEN-1:`XLEN];
			fu_pkg::ALU_MULHSU: next_result = mixed_product[2*`XLEN-1:`XLEN];
			fu_pkg::ALU_MULHU:  next_result = unsigned_product[2*`XLEN-1:`XLEN];
			default:            next_result = `ALU_BAD_RESULT;
		endcase
	end

	// branch compare works on the raw register values, not the muxed operands
	always_comb begin
		case (br_funct3)
			3'b000:  next_cond = rs1_value == rs2_value; // beq
			3'b001:  next_cond = rs1_value != rs2_value; // bne
			3'b100:  next_cond = $signed(rs1_value) < $signed(rs2_value);  // blt
			3'b101:  next_cond = $signed(rs1_value) >= $signed(rs2_value); // bge
			3'b110:  next_cond = rs1_value < rs2_value;  // bltu
			3'b111:  next_cond = rs1_value >= rs2_value; // bgeu
			default: next_cond = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			count      <= `ALU_LATENCY'(1);
			valid_q    <= 1'b0;
			alu_result <= '0;
			cond       <= 1'b0;
		end else if (!operands_valid) begin
			count   <= `ALU_LATENCY'(1); // wait for the slot to fill
			valid_q <= 1'b0;
		end else if (restart) begin
			// slot refilled on the previous edge, that edge already counts
			count      <= `ALU_LATENCY'(2);
			valid_q    <= 1'b0;
			alu_result <= next_result;
			cond       <= next_cond;
		end else begin
			if (!count[`ALU_LATENCY-1]) begin
				count <= {count[`ALU_LATENCY-2:0], 1'b0};
			end
			valid_q    <= count[`ALU_LATENCY-1];
			alu_result <= next_result;
			cond       <= next_cond;
		end
	end

	// stale result is hidden in the cycle after a release
	assign valid = valid_q & ~restart;

endmodule

//--- fu_alu.sv
`timescale 1ns/100ps

`include "fu_config.svh"

module fu_alu (
	input  logic                      clock,
	input  logic                      reset,
	input  fu_pkg::dispatch_packet_t  dispatch,
	input  fu_pkg::operand_packet_t   operands,
	input  logic                      select,
	input  logic                      squash,
	output fu_pkg::fu_result_t        result,
	output logic                      result_valid,
	output logic                      slot_busy
);

	fu_pkg::dispatch_packet_t held_dispatch;
	fu_pkg::operand_packet_t  held_operands;
	logic                     restart;
	logic [`XLEN-1:0]         opa;
	logic [`XLEN-1:0]         opb;
	logic [`XLEN-1:0]         alu_result;
	logic                     cond;
	logic                     core_valid;

	fu_slot slot (
		.clock         (clock),
		.reset         (reset),
		.dispatch      (dispatch),
		.operands      (operands),
		.select        (select),
		.squash        (squash),
		.held_dispatch (held_dispatch),
		.held_operands (held_operands),
		.restart       (restart),
		.slot_busy     (slot_busy)
	);

	fu_operand_mux operand_mux (
		.held_dispatch (held_dispatch),
		.held_operands (held_operands),
		.opa           (opa),
		.opb           (opb)
	);

	alu_core core (
		.clock          (clock),
		.reset          (reset),
		.restart        (restart),
		.operands_valid (held_operands.valid),
		.opa            (opa),
		.opb            (opb),
		.rs1_value      (held_operands.rs1_value),
		.rs2_value      (held_operands.rs2_value),
		.func           (held_dispatch.alu_func),
		.br_funct3      (held_dispatch.inst.b.funct3),
		.valid          (core_valid),
		.alu_result     (alu_result),
		.cond           (cond)
	);

	assign result.npc         = held_dispatch.npc;
	assign result.alu_result  = alu_result;
	// jumps always redirect, branches only when the compare holds
	assign result.take_branch = held_dispatch.uncond_branch |
		(held_dispatch.cond_branch & cond);
	assign result.dest_reg    = held_dispatch.dest_reg;
	assign result.rs2_value   = held_operands.rs2_value;

	assign result_valid = held_dispatch.valid & core_valid;

endmodule

//--- fu_alu_tb_tasks.svh
task automatic compare_result(input string name, input fu_pkg::fu_result_t expected,
	input fu_pkg::fu_result_t actual);
	if (actual !== expected) begin
		$display("mismatch %s expected %h actual %h", name, expected, actual);
		mismatch_count++;
	end
endtask

task automatic compare_bit(input string name, input logic expected, input logic actual);
	if (actual !== expected) begin
		$display("mismatch %s expected %b actual %b", name, expected, actual);
		mismatch_count++;
	end
endtask

// entered on the falling edge right after the fill edge
task automatic wait_for_valid(input string name);
	int edges;
	edges = 0;
	compare_bit({name, " valid timing"}, 1'b0, result_valid);
	while (!result_valid && edges < WAIT_LIMIT) begin
		@(negedge clock);
		edges++;
		if (edges <= `ALU_LATENCY) begin
			compare_bit({name, " valid timing"}, edges == `ALU_LATENCY, result_valid);
		end
	end
	if (!result_valid) begin
		$display("%s timed out waiting for result_valid", name);
		timeout_count++;
	end
endtask

task automatic present_packets(input string name, input fu_pkg::dispatch_packet_t d,
	input fu_pkg::operand_packet_t o);
	@(negedge clock);
	dispatch = d;
	operands = o;
	@(negedge clock);
	dispatch.valid = 1'b0; // both taken on the edge just passed
	operands.valid = 1'b0;
	compare_bit({name, " slot_busy"}, 1'b1, slot_busy);
endtask

task automatic release_result(input string name, input logic busy_after);
	@(negedge clock);
	select = 1'b1;
	@(negedge clock);
	select         = 1'b0;
	dispatch.valid = 1'b0;
	operands.valid = 1'b0;
	compare_bit({name, " valid after select"}, 1'b0, result_valid);
	compare_bit({name, " busy after select"}, busy_after, slot_busy);
endtask

task automatic run_check(input string name, input fu_pkg::dispatch_packet_t d,
	input logic [31:0] rs1, input logic [31:0] rs2);
	fu_pkg::operand_packet_t o;
	o = '{valid: 1'b1, rs1_value: rs1, rs2_value: rs2};
	present_packets(name, d, o);
	wait_for_valid(name);
	compare_result(name, expected_result(d, o), result);
	release_result(name, 1'b0);
endtask

task automatic alu_functions();
	fu_pkg::alu_func_e        func;
	fu_pkg::dispatch_packet_t d;
	logic [31:0]              rs1;
	logic [31:0]              rs2;
	compare_bit("reset result_valid", 1'b0, result_valid);
	compare_bit("reset slot_busy", 1'b0, slot_busy);
	compare_result("reset result", '0, result);
	for (int f = 0; f <= 9; f++) begin
		func = fu_pkg::alu_func_e'(f);
		for (int k = 0; k < 4; k++) begin
			rs1 = random_bits(32);
			rs2 = random_bits(32);
			if (k == 1) rs1[31] = 1'b1; // negative source
			if (k == 3) rs2[4:0] = 5'd31; // largest shift with random upper bits
			d = make_dispatch(func, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_RS2, random_bits(32),
				1'b0, 1'b0);
			run_check($sformatf("basic %s %0d", func.name(), k), d, rs1, rs2);
		end
	end
endtask

task automatic multiply_functions();
	logic [31:0]              corner [4];
	fu_pkg::alu_func_e        func;
	fu_pkg::dispatch_packet_t d;
	logic [31:0]              rs1;
	logic [31:0]              rs2;
	corner = '{32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff, 32'h0000_0003};
	for (int f = 10; f <= 13; f++) begin
		func = fu_pkg::alu_func_e'(f);
		for (int k = 0; k < 20; k++) begin
			rs1 = (k < 16) ? corner[k / 4] : random_bits(32);
			rs2 = (k < 16) ? corner[k % 4] : random_bits(32);
			d = make_dispatch(func, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_RS2, random_bits(32),
				1'b0, 1'b0);
			run_check($sformatf("multiply %s %0d", func.name(), k), d, rs1, rs2);
		end
	end
endtask

task automatic operand_selection();
	fu_pkg::opa_sel_e         opa_sel;
	fu_pkg::opb_sel_e         opb_sel;
	fu_pkg::dispatch_packet_t d;
	for (int s = 1; s <= 5; s++) begin
		opb_sel = fu_pkg::opb_sel_e'(s);
		d = make_dispatch(fu_pkg::ALU_ADD, fu_pkg::OPA_IS_RS1, opb_sel, random_bits(32),
			1'b0, 1'b0);
		run_check($sformatf("opb %s", opb_sel.name()), d, random_bits(32), random_bits(32));
	end
	for (int s = 1; s <= 3; s++) begin
		opa_sel = fu_pkg::opa_sel_e'(s);
		d = make_dispatch(fu_pkg::ALU_ADD, opa_sel, fu_pkg::OPB_IS_RS2, random_bits(32),
			1'b0, 1'b0);
		run_check($sformatf("opa %s", opa_sel.name()), d, random_bits(32), random_bits(32));
	end
endtask

task automatic branch_outcomes();
	logic [31:0]              left [5];
	logic [31:0]              right [5];
	logic [31:0]              same;
	logic [31:0]              word;
	fu_pkg::dispatch_packet_t d;
	same  = random_bits(32);
	// equal, less, greater, then pairs whose signs differ
	left  = '{same, 32'd5, 32'd9, 32'hffff_fff0, 32'h0000_0010};
	right = '{same, 32'd9, 32'd5, 32'h0000_0010, 32'hffff_fff0};
	for (int f3 = 0; f3 < 8; f3++) begin
		for (int p = 0; p < 5; p++) begin
			word        = random_bits(32);
			word[14:12] = 3'(f3);
			word[6:0]   = 7'b1100011;
			d = make_dispatch(fu_pkg::ALU_ADD, fu_pkg::OPA_IS_PC, fu_pkg::OPB_IS_B_IMM, word,
				1'b1, 1'b0);
			run_check($sformatf("branch funct3 %0d pair %0d", f3, p), d, left[p], right[p]);
		end
	end
	for (int p = 0; p < 5; p++) begin
		d = make_dispatch(fu_pkg::ALU_ADD, fu_pkg::OPA_IS_PC, fu_pkg::OPB_IS_J_IMM,
			random_bits(32), 1'b0, 1'b1); // jump taken whatever the compare says
		run_check($sformatf("jump pair %0d", p), d, left[p], right[p]);
	end
endtask

task automatic backpressure_hold();
	fu_pkg::dispatch_packet_t first;
	fu_pkg::dispatch_packet_t waiting;
	fu_pkg::operand_packet_t  first_ops;
	fu_pkg::operand_packet_t  waiting_ops;
	fu_pkg::fu_result_t       held;
	first = make_dispatch(fu_pkg::ALU_SUB, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_RS2,
		random_bits(32), 1'b0, 1'b0);
	waiting = make_dispatch(fu_pkg::ALU_XOR, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_RS2,
		random_bits(32), 1'b0, 1'b0);
	first_ops   = '{valid: 1'b1, rs1_value: random_bits(32), rs2_value: random_bits(32)};
	waiting_ops = '{valid: 1'b1, rs1_value: random_bits(32), rs2_value: random_bits(32)};
	@(negedge clock);
	dispatch = first;
	@(negedge clock);
	dispatch.valid = 1'b0;
	compare_bit("late operands slot_busy", 1'b1, slot_busy);
	repeat (4) begin
		@(negedge clock);
		compare_bit("late operands no early valid", 1'b0, result_valid);
	end
	operands = first_ops; // fill edge comes with the operands
	@(negedge clock);
	operands.valid = 1'b0;
	wait_for_valid("late operands");
	held = expected_result(first, first_ops);
	compare_result("late operands", held, result);
	dispatch = waiting;
	operands = waiting_ops;
	repeat (20) begin
		@(negedge clock);
		compare_result("backpressure hold", held, result);
		compare_bit("backpressure valid", 1'b1, result_valid);
		compare_bit("backpressure busy", 1'b1, slot_busy);
	end
	release_result("backpressure", 1'b1); // waiting packets enter on the select edge
	wait_for_valid("refill on select");
	compare_result("refill on select", expected_result(waiting, waiting_ops), result);
	release_result("refill on select", 1'b0);
endtask

task automatic squash_recovery();
	fu_pkg::dispatch_packet_t d;
	fu_pkg::operand_packet_t  o;
	d = make_dispatch(fu_pkg::ALU_OR, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_RS2, random_bits(32),
		1'b0, 1'b0);
	o = '{valid: 1'b1, rs1_value: random_bits(32), rs2_value: random_bits(32)};
	present_packets("squash", d, o);
	wait_for_valid("squash");
	@(negedge clock);
	squash = 1'b1;
	@(negedge clock);
	squash = 1'b0;
	compare_bit("squash result_valid", 1'b0, result_valid);
	compare_bit("squash slot_busy", 1'b0, slot_busy);
	d = make_dispatch(fu_pkg::ALU_SLTU, fu_pkg::OPA_IS_RS1, fu_pkg::OPB_IS_RS2,
		random_bits(32), 1'b0, 1'b0);
	run_check("after squash", d, random_bits(32), random_bits(32));
endtask

//--- fu_alu_tb.sv
`timescale 1ns/100ps

`include "fu_config.svh"

module fu_alu_tb;

	localparam int WAIT_LIMIT = 40; // cycles before a wait gives up

	logic                     clock;
	logic                     reset;
	fu_pkg::dispatch_packet_t dispatch;
	fu_pkg::operand_packet_t  operands;
	logic                     select;
	logic                     squash;
	fu_pkg::fu_result_t       result;
	logic                     result_valid;
	logic                     slot_busy;
	logic [31:0]              lfsr_state;
	int                       mismatch_count;
	int                       timeout_count;

	fu_alu UUT (
		.clock        (clock),
		.reset        (reset),
		.dispatch     (dispatch),
		.operands     (operands),
		.select       (select),
		.squash       (squash),
		.result       (result),
		.result_valid (result_valid),
		.slot_busy    (slot_busy)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	// galois lfsr stepped once for every bit shifted into the word
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int n = 0; n < count; n++) begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
		end
		return value;
	endfunction

	// reference alu with products taken on 64-bit extended operands
	function automatic logic [31:0] model_alu(input fu_pkg::alu_func_e func,
		input logic [31:0] a, input logic [31:0] b);
		logic [63:0] wide_a;
		logic [63:0] wide_b;
		logic [63:0] product;
		wide_a  = (func == fu_pkg::ALU_MULH || func == fu_pkg::ALU_MULHSU) ?
			{{32{a[31]}}, a} : {32'h0, a};
		wide_b  = (func == fu_pkg::ALU_MULH) ? {{32{b[31]}}, b} : {32'h0, b};
		product = wide_a * wide_b;
		case (func)
			fu_pkg::ALU_ADD:  return a + b;
			fu_pkg::ALU_SUB:  return a - b;
			fu_pkg::ALU_AND:  return a & b;
			fu_pkg::ALU_OR:   return a | b;
			fu_pkg::ALU_XOR:  return a ^ b;
			fu_pkg::ALU_SLT:  return ((a ^ 32'h8000_0000) < (b ^ 32'h8000_0000)) ? 32'd1 : 32'd0;
			fu_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
			fu_pkg::ALU_SLL:  return a << b[4:0];
			fu_pkg::ALU_SRL:  return a >> b[4:0];
			fu_pkg::ALU_SRA:  return 32'({{32{a[31]}}, a} >> b[4:0]); // sign bits shift in
			fu_pkg::ALU_MUL:  return product[31:0];
			fu_pkg::ALU_MULH, fu_pkg::ALU_MULHSU, fu_pkg::ALU_MULHU: return product[63:32];
			default:          return `ALU_BAD_RESULT;
		endcase
	endfunction

	function automatic logic model_branch(input logic [2:0] funct3,
		input logic [31:0] a, input logic [31:0] b);
		logic less_signed;
		less_signed = (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
		case (funct3)
			3'd0:    return a == b;
			3'd1:    return a != b;
			3'd4:    return less_signed;
			3'd5:    return !less_signed;
			3'd6:    return a < b;
			3'd7:    return !(a < b);
			default: return 1'b0;
		endcase
	endfunction

	// expected packet with immediates rebuilt from raw rv32 bit positions
	function automatic fu_pkg::fu_result_t expected_result(input fu_pkg::dispatch_packet_t d,
		input fu_pkg::operand_packet_t o);
		logic [31:0]        w;
		logic [31:0]        a;
		logic [31:0]        b;
		fu_pkg::fu_result_t r;
		w = d.inst;
		case (d.opa_select)
			fu_pkg::OPA_IS_RS1: a = o.rs1_value;
			fu_pkg::OPA_IS_NPC: a = d.npc;
			fu_pkg::OPA_IS_PC:  a = d.pc;
			default:            a = '0;
		endcase
		case (d.opb_select)
			fu_pkg::OPB_IS_RS2:   b = o.rs2_value;
			fu_pkg::OPB_IS_I_IMM: b = {{20{w[31]}}, w[31:20]};
			fu_pkg::OPB_IS_S_IMM: b = {{20{w[31]}}, w[31:25], w[11:7]};
			fu_pkg::OPB_IS_B_IMM: b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			fu_pkg::OPB_IS_U_IMM: b = {w[31:12], 12'h000};
			fu_pkg::OPB_IS_J_IMM: b = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			default:              b = '0;
		endcase
		r.npc         = d.npc;
		r.alu_result  = model_alu(d.alu_func, a, b);
		r.take_branch = d.uncond_branch |
			(d.cond_branch & model_branch(w[14:12], o.rs1_value, o.rs2_value));
		r.dest_reg    = d.dest_reg;
		r.rs2_value   = o.rs2_value;
		return r;
	endfunction

	function automatic fu_pkg::dispatch_packet_t make_dispatch(input fu_pkg::alu_func_e func,
		input fu_pkg::opa_sel_e opa_sel, input fu_pkg::opb_sel_e opb_sel,
		input logic [31:0] word, input logic cond_branch, input logic uncond_branch);
		fu_pkg::dispatch_packet_t d;
		d.valid         = 1'b1;
		d.pc            = random_bits(30) << 2; // word aligned
		d.npc           = d.pc + 32'd4;
		d.inst          = word;
		d.opa_select    = opa_sel;
		d.opb_select    = opb_sel;
		d.alu_func      = func;
		d.cond_branch   = cond_branch;
		d.uncond_branch = uncond_branch;
		d.dest_reg      = 5'(random_bits(5));
		return d;
	endfunction

	`include "fu_alu_tb_tasks.svh"

	initial begin
		lfsr_state     = 32'ha356_c05d;
		mismatch_count = 0;
		timeout_count  = 0;
		reset          = 1'b1;
		dispatch       = '0;
		operands       = '0;
		select         = 1'b0;
		squash         = 1'b0;
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		alu_functions();
		multiply_functions();
		operand_selection();
		branch_outcomes();
		backpressure_hold();
		squash_recovery();
		$display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
		if (mismatch_count == 0 && timeout_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+.
fu_pkg.sv
fu_slot.sv
fu_operand_mux.sv
alu_core.sv
fu_alu.sv
fu_alu_tb.sv

//--- Bender.yml
package:
  name: fu_alu

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - fu_pkg.sv
      - fu_slot.sv
      - fu_operand_mux.sv
      - alu_core.sv
      - fu_alu.sv
      - target: test
        files:
          - fu_alu_tb.sv
